//--- hw/sha256_pkg.sv
package sha256_pkg;

  typedef logic [31:0]  word_t;
  typedef logic [5:0]   round_idx_t;
  typedef logic [511:0] block_t;
  typedef logic [255:0] digest_t;

  // Element 0 is a (or H0) and sits in the most significant bits
  typedef word_t [0:7] state_t;

  typedef enum logic [1:0] {
    CTRL_IDLE   = 2'h0,
    CTRL_ROUNDS = 2'h1,
    CTRL_DONE   = 2'h2
  } ctrl_state_t;

  parameter int NUM_ROUNDS      = 64;
  parameter int NUM_SCHED_WORDS = 16;

  // ----------------------------------------------------------
  // Constants from FIPS 180-4
  // ----------------------------------------------------------
  parameter word_t ROUND_K [0:NUM_ROUNDS-1] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  parameter state_t IV_SHA256 = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

  parameter state_t IV_SHA224 = {
    32'hc1059ed8, 32'h367cd507, 32'h3070dd17, 32'hf70e5939,
    32'hffc00b31, 32'h68581511, 32'h64f98fa7, 32'hbefa4fa4
  };

  // ----------------------------------------------------------
  // Bit functions
  // ----------------------------------------------------------
  function automatic word_t rotr(word_t x, int unsigned n);
    return (x >> n) | (x << (32 - n));
  endfunction

  function automatic word_t big_sigma0(word_t x);
    return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
  endfunction

  function automatic word_t big_sigma1(word_t x);
    return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
  endfunction

  function automatic word_t small_sigma0(word_t x);
    return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
  endfunction

  function automatic word_t small_sigma1(word_t x);
    return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
  endfunction

  function automatic word_t choose(word_t x, word_t y, word_t z);
    return (x & y) ^ (~x & z);
  endfunction

  function automatic word_t majority(word_t x, word_t y, word_t z);
    return (x & y) ^ (x & z) ^ (y & z);
  endfunction

endpackage

//--- hw/sha256_word_if.sv
`timescale 1ns/1ps

interface sha256_word_if;

  sha256_pkg::round_idx_t round;
  logic                   load;
  logic                   advance;
  sha256_pkg::word_t      w;

  modport ctrl (
    output round,
    output load,
    output advance
  );

  modport sched (
    input  round,
    input  load,
    input  advance,
    output w
  );

  // Round datapath follows the index, the advance strobe and the word
  modport rnd (
    input round,
    input load,
    input advance,
    input w
  );

endinterface

//--- hw/sha256_chain_if.sv
`timescale 1ns/1ps

interface sha256_chain_if;

  sha256_pkg::state_t chain;
  sha256_pkg::state_t work;
  logic               load;
  logic               finish;

  modport hold (
    output chain,
    input  work,
    input  load,
    input  finish
  );

  modport rnd (
    output work,
    input  chain,
    input  load
  );

  modport ctrl (
    output load,
    output finish
  );

endinterface

//--- hw/sha256_ctrl.sv
`timescale 1ns/1ps

module sha256_ctrl (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         init,
  input  logic         next,
  output logic         ready,
  output logic         digest_valid,
  sha256_word_if.ctrl  wif,
  sha256_chain_if.ctrl cif
);

  sha256_pkg::ctrl_state_t state_q;
  sha256_pkg::round_idx_t  round_q;
  logic                    start;
  logic                    last_round;

  // Commands only count while idle; anything else is dropped
  assign start      = (state_q == sha256_pkg::CTRL_IDLE) && (init || next);
  assign last_round = (round_q == sha256_pkg::round_idx_t'(sha256_pkg::NUM_ROUNDS - 1));

  assign wif.round   = round_q;
  assign wif.load    = start;
  assign wif.advance = (state_q == sha256_pkg::CTRL_ROUNDS);
  assign cif.load    = start;
  assign cif.finish  = (state_q == sha256_pkg::CTRL_DONE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= sha256_pkg::CTRL_IDLE;
      round_q      <= '0;
      ready        <= 1'b1;
      digest_valid <= 1'b0;
    end else begin
      case (state_q)
        sha256_pkg::CTRL_IDLE: begin
          if (start) begin
            state_q      <= sha256_pkg::CTRL_ROUNDS;
            round_q      <= '0;
            ready        <= 1'b0;
            digest_valid <= 1'b0;
          end
        end
        sha256_pkg::CTRL_ROUNDS: begin
          // Counter wraps back to 0 after round 63
          round_q <= round_q + 1'b1;
          if (last_round) begin
            state_q <= sha256_pkg::CTRL_DONE;
          end
        end
        sha256_pkg::CTRL_DONE: begin
          state_q      <= sha256_pkg::CTRL_IDLE;
          ready        <= 1'b1;
          digest_valid <= 1'b1;
        end
        default: begin
          state_q <= sha256_pkg::CTRL_IDLE;
        end
      endcase
    end
  end

endmodule

//--- hw/sha256_msg_schedule.sv
`timescale 1ns/1ps

module sha256_msg_schedule (
  input  logic                clk,
  input  logic                rst_n,
  input  sha256_pkg::block_t  block,
  sha256_word_if.sched        wif
);

  sha256_pkg::word_t w_mem [sha256_pkg::NUM_SCHED_WORDS];
  sha256_pkg::word_t w_new;
  logic              late_round;

  // From round 16 on the window holds W[t-16] to W[t-1]
  assign late_round = (wif.round >=
                       sha256_pkg::round_idx_t'(sha256_pkg::NUM_SCHED_WORDS));

  assign w_new = sha256_pkg::small_sigma1(w_mem[14]) + w_mem[9] +
                 sha256_pkg::small_sigma0(w_mem[1]) + w_mem[0];

  assign wif.w = late_round ? w_new : w_mem[wif.round[3:0]];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < sha256_pkg::NUM_SCHED_WORDS; i++) begin
        w_mem[i] <= '0;
      end
    end else if (wif.load) begin
      // Word 0 comes from the top of the block
      for (int i = 0; i < sha256_pkg::NUM_SCHED_WORDS; i++) begin
        w_mem[i] <= block[(sha256_pkg::NUM_SCHED_WORDS - 1 - i) * 32 +: 32];
      end
    end else if (wif.advance && late_round) begin
      for (int i = 0; i < sha256_pkg::NUM_SCHED_WORDS - 1; i++) begin
        w_mem[i] <= w_mem[i + 1];
      end
      w_mem[sha256_pkg::NUM_SCHED_WORDS - 1] <= w_new;
    end
  end

endmodule

//--- hw/sha256_round.sv
`timescale 1ns/1ps

module sha256_round (
  input  logic        clk,
  input  logic        rst_n,
  sha256_word_if.rnd  wif,
  sha256_chain_if.rnd cif
);

  sha256_pkg::state_t work_q;
  sha256_pkg::word_t  a;
  sha256_pkg::word_t  b;
  sha256_pkg::word_t  c;
  sha256_pkg::word_t  d;
  sha256_pkg::word_t  e;
  sha256_pkg::word_t  f;
  sha256_pkg::word_t  g;
  sha256_pkg::word_t  h;
  sha256_pkg::word_t  t1;
  sha256_pkg::word_t  t2;

  assign a = work_q[0];
  assign b = work_q[1];
  assign c = work_q[2];
  assign d = work_q[3];
  assign e = work_q[4];
  assign f = work_q[5];
  assign g = work_q[6];
  assign h = work_q[7];

  // ----------------------------------------------------------
  // One compression round
  // ----------------------------------------------------------
  always_comb begin
    t1 = h + sha256_pkg::big_sigma1(e) + sha256_pkg::choose(e, f, g) +
         sha256_pkg::ROUND_K[wif.round] + wif.w;
    t2 = sha256_pkg::big_sigma0(a) + sha256_pkg::majority(a, b, c);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      work_q <= '0;
    end else if (cif.load) begin
      work_q <= cif.chain;
    end else if (wif.advance) begin
      work_q <= {t1 + t2, a, b, c, d + t1, e, f, g};
    end
  end

  assign cif.work = work_q;

endmodule

//--- hw/sha256_hash_state.sv
`timescale 1ns/1ps

module sha256_hash_state (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                init,
  input  logic                mode,
  output sha256_pkg::digest_t digest,
  sha256_chain_if.hold        cif
);

  sha256_pkg::state_t h_q;
  sha256_pkg::state_t h_sum;

  // A new message starts from the IV, a chained block from the last H
  assign cif.chain = init ? (mode ? sha256_pkg::IV_SHA256 : sha256_pkg::IV_SHA224) : h_q;

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      h_sum[i] = h_q[i] + cif.work[i];
    end
  end

  // ----------------------------------------------------------
  // Chaining registers and digest
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_q <= '0;
    end else if (cif.load) begin
      h_q <= cif.chain;
    end else if (cif.finish) begin
      h_q <= h_sum;
    end
  end

  // H0 lands in the top word of the digest
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      digest <= '0;
    end else if (cif.finish) begin
      digest <= h_sum;
    end
  end

endmodule

//--- hw/sha256_core.sv
`timescale 1ns/1ps

module sha256_core (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                init,
  input  logic                next,
  input  logic                mode,
  input  sha256_pkg::block_t  block,
  output logic                ready,
  output sha256_pkg::digest_t digest,
  output logic                digest_valid
);

  // ----------------------------------------------------------
  // Internal links
  // ----------------------------------------------------------
  sha256_word_if  u_word_if ();
  sha256_chain_if u_chain_if ();

  sha256_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .init         (init),
    .next         (next),
    .ready        (ready),
    .digest_valid (digest_valid),
    .wif          (u_word_if.ctrl),
    .cif          (u_chain_if.ctrl)
  );

  // ----------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------
  sha256_msg_schedule u_msg_schedule (
    .clk   (clk),
    .rst_n (rst_n),
    .block (block),
    .wif   (u_word_if.sched)
  );

  sha256_round u_round (
    .clk   (clk),
    .rst_n (rst_n),
    .wif   (u_word_if.rnd),
    .cif   (u_chain_if.rnd)
  );

  sha256_hash_state u_hash_state (
    .clk    (clk),
    .rst_n  (rst_n),
    .init   (init),
    .mode   (mode),
    .digest (digest),
    .cif    (u_chain_if.hold)
  );

endmodule

//--- verification/tb_sha256_core.sv
`timescale 1ns/1ps

module tb_sha256_core;

  // Five hashes of 65 cycles each plus reset and idle gaps, with generous margin
  localparam int MAX_CYCLES = 1000;
  localparam int LATENCY    = 65;

  localparam sha256_pkg::block_t ABC_BLOCK = {32'h61626380, 448'h0, 32'h00000018};

  localparam sha256_pkg::block_t MSG_BLOCK1 = {
    32'h61626364, 32'h62636465, 32'h63646566, 32'h64656667,
    32'h65666768, 32'h66676869, 32'h6768696a, 32'h68696a6b,
    32'h696a6b6c, 32'h6a6b6c6d, 32'h6b6c6d6e, 32'h6c6d6e6f,
    32'h6d6e6f70, 32'h6e6f7071, 32'h80000000, 32'h00000000
  };
  localparam sha256_pkg::block_t MSG_BLOCK2 = {480'h0, 32'h000001c0};

  localparam sha256_pkg::digest_t SHA256_ABC = {
    32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
    32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad
  };
  localparam sha256_pkg::digest_t SHA256_TWO_BLOCK = {
    32'h248d6a61, 32'hd20638b8, 32'he5c02693, 32'h0c3e6039,
    32'ha33ce459, 32'h64ff2167, 32'hf6ecedd4, 32'h19db06c1
  };
  localparam sha256_pkg::word_t SHA224_ABC [0:6] = '{
    32'h23097d22, 32'h3405d822, 32'h8642a477, 32'hbda255b3,
    32'h2aadbce4, 32'hbda0b3f7, 32'he36c9da7
  };

  logic                clk;
  logic                rst_n;
  logic                init;
  logic                next;
  logic                mode;
  sha256_pkg::block_t  block;
  logic                ready;
  sha256_pkg::digest_t digest;
  logic                digest_valid;

  int errors;
  int cycle_count;

  sha256_core u_sha256_core (
    .clk          (clk),
    .rst_n        (rst_n),
    .init         (init),
    .next         (next),
    .mode         (mode),
    .block        (block),
    .ready        (ready),
    .digest       (digest),
    .digest_valid (digest_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic check_digest(input string name, input sha256_pkg::digest_t got,
                              input sha256_pkg::digest_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input sha256_pkg::word_t got,
                            input sha256_pkg::word_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // ------------------------------------------------------------
  // Driver
  // ------------------------------------------------------------
  // Inputs change and outputs are read 2 ns after each rising edge
  task automatic step_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic issue_command(input logic use_init, input logic mode_in,
                               input sha256_pkg::block_t blk);
    init  = use_init;
    next  = ~use_init;
    mode  = mode_in;
    block = blk;
    step_cycle();
    init = 1'b0;
    next = 1'b0;
    check_bit("ready", ready, 1'b0);
    check_bit("digest_valid", digest_valid, 1'b0);
  endtask

  task automatic wait_digest(output int cycles);
    cycles = 0;
    while (digest_valid !== 1'b1) begin
      check_bit("ready", ready, 1'b0);
      step_cycle();
      cycles++;
    end
    check_bit("ready", ready, 1'b1);
  endtask

  task automatic run_block(input logic use_init, input logic mode_in,
                           input sha256_pkg::block_t blk, output int cycles);
    issue_command(use_init, mode_in, blk);
    wait_digest(cycles);
  endtask

  task automatic check_latency(input int cycles);
    if (cycles != LATENCY) begin
      $display("digest_valid rose %0d cycles after the command, expected %0d",
               cycles, LATENCY);
      errors++;
    end
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic test_reset();
    check_bit("ready", ready, 1'b1);
    check_bit("digest_valid", digest_valid, 1'b0);
    check_digest("digest", digest, '0);
  endtask

  task automatic test_sha256_abc();
    int cycles;
    run_block(1'b1, 1'b1, ABC_BLOCK, cycles);
    check_latency(cycles);
    check_digest("digest", digest, SHA256_ABC);
  endtask

  task automatic test_sha224_abc();
    int cycles;
    run_block(1'b1, 1'b0, ABC_BLOCK, cycles);
    check_latency(cycles);
    for (int i = 0; i < 7; i++) begin
      check_word($sformatf("digest word %0d", i), digest[255 - 32 * i -: 32], SHA224_ABC[i]);
    end
  endtask

  task automatic test_chaining();
    int cycles;
    run_block(1'b1, 1'b1, MSG_BLOCK1, cycles);
    check_latency(cycles);
    run_block(1'b0, 1'b1, MSG_BLOCK2, cycles);
    check_latency(cycles);
    check_digest("digest", digest, SHA256_TWO_BLOCK);
  endtask

  task automatic test_busy_ignored();
    int cycles;
    int rest;
    issue_command(1'b1, 1'b1, ABC_BLOCK);
    cycles = 0;
    repeat (5) begin
      check_bit("ready", ready, 1'b0);
      step_cycle();
      cycles++;
    end
    // A new message while busy must be dropped
    init  = 1'b1;
    mode  = 1'b0;
    block = MSG_BLOCK1;
    step_cycle();
    cycles++;
    init = 1'b0;
    wait_digest(rest);
    check_latency(cycles + rest);
    check_digest("digest", digest, SHA256_ABC);
    repeat (10) begin
      step_cycle();
      check_digest("digest", digest, SHA256_ABC);
      check_bit("digest_valid", digest_valid, 1'b1);
      check_bit("ready", ready, 1'b1);
    end
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, digest_valid never arrived", MAX_CYCLES);
    $display("Errors: %0d", errors);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    errors = 0;
    rst_n  = 1'b0;
    init   = 1'b0;
    next   = 1'b0;
    mode   = 1'b0;
    block  = '0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    step_cycle();

    test_reset();
    test_sha256_abc();
    test_sha224_abc();
    test_chaining();
    test_busy_ignored();

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- sha256_core.f
hw/sha256_pkg.sv
hw/sha256_word_if.sv
hw/sha256_chain_if.sv
hw/sha256_ctrl.sv
hw/sha256_msg_schedule.sv
hw/sha256_round.sv
hw/sha256_hash_state.sv
hw/sha256_core.sv
verification/tb_sha256_core.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_sha256_core \
  -Mdir obj_dir \
  -f sha256_core.f

./obj_dir/Vtb_sha256_core > sim.log 2>&1
cat sim.log

if grep -q "TEST OK" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
